// File: ifu_top.f
+incdir+include
src/ifu_pkg.sv
src/ifu_fetch_req.sv
src/ifu_iq.sv
src/ifu_fdp.sv
src/ifu_top.sv
verification/ifu_checker.sv
verification/ifu_tb.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary
LINT_FLAGS ?= --lint-only --timing
TOP        := ifu_tb
FILELIST   := ifu_top.f
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/ifu_tb.sv
`default_nettype none
`include "ifu_defs.svh"

module ifu_tb;

   // decodes per test
   localparam int N_SEQ    = 24;
   localparam int N_BR     = 20;
   localparam int N_EXC    = 20;
   localparam int N_STALL  = 16;
   localparam int N_MIX    = 40;
   localparam int TIMEOUT  = (N_SEQ + N_BR + N_EXC + N_STALL + N_MIX) * 6;
   localparam logic [`GRLEN-1:0] PC_RESET = 32'h0000_1000;

   logic                     clk = 1'b0;
   logic                     rst_n;
   logic                     ifu_icu_req_ic1;
   logic [`GRLEN-1:0]        ifu_icu_addr_ic1;
   wire                      icu_ifu_ack_ic1;
   logic                     ifu_icu_cancel;
   logic [`IFU_BLOCK_W-1:0]  icu_ifu_data_ic2;
   logic                     icu_ifu_data_valid_ic2;
   logic                     br_taken;
   logic [`GRLEN-1:0]        br_target;
   logic                     exu_ifu_except;
   logic [`GRLEN-1:0]        exu_ifu_eentry;
   logic                     exu_ifu_ertn_e;
   logic [`GRLEN-1:0]        exu_ifu_era;
   logic                     exu_ifu_stall_req;
   logic [`GRLEN-1:0]        fdp_dec_pc_d;
   logic [`GRLEN-1:0]        fdp_dec_inst_d;
   logic                     fdp_dec_inst_kill_vld_d;
   logic                     ifu_exu_valid_e;
   logic [`GRLEN-1:0]        ifu_exu_pc_e;
   logic [`GRLEN-1:0]        ifu_exu_pc_w;
   int                       dec_count;
   int                       err_count;
   int                       cycles = 0;
   int                       tests_failed = 0;
   logic [31:0]              stim_lfsr = 32'd85658;
   logic [31:0]              mem_lfsr = 32'd85658;
   logic                     pend;
   logic [`GRLEN-1:0]        pend_addr;
   logic [2:0]               pend_cnt;

   always #4 clk = ~clk;

   ifu_top UUT (.*, .pc_init(PC_RESET));

   ifu_checker u_checker (.*, .pc_init(PC_RESET));

   // fibonacci, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [`GRLEN-1:0] mem_word(input logic [`GRLEN-1:0] a);
      return (a * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
   endfunction

   // aligned block, low word at the lower address
   function automatic logic [`IFU_BLOCK_W-1:0] block_at(input logic [`GRLEN-1:0] a);
      return {mem_word({a[31:3], 3'b100}), mem_word({a[31:3], 3'b000})};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      int i;
      v = '0;
      for (i = 0; i < n; i++) begin
         v = {v[30:0], stim_lfsr[31]};
         stim_lfsr = lfsr_step(stim_lfsr);
      end
   endtask

   // ====================================================================
   // instruction memory model
   // ====================================================================
   assign icu_ifu_ack_ic1 = ifu_icu_req_ic1;

   always @(posedge clk) begin : mem_model
      logic [1:0] d;
      icu_ifu_data_valid_ic2 <= 1'b0;
      if (!rst_n) begin
         pend <= 1'b0;
      end else if (ifu_icu_req_ic1) begin
         // latency 1 to 4, also replaces a cancelled fetch
         d[1] = mem_lfsr[31];
         mem_lfsr = lfsr_step(mem_lfsr);
         d[0] = mem_lfsr[31];
         mem_lfsr = lfsr_step(mem_lfsr);
         pend      <= 1'b1;
         pend_addr <= ifu_icu_addr_ic1;
         pend_cnt  <= {1'b0, d} + 3'd1;
      end else if (ifu_icu_cancel) begin
         pend <= 1'b0;
      end else if (pend) begin
         if (pend_cnt == 3'd1) begin
            icu_ifu_data_valid_ic2 <= 1'b1;
            icu_ifu_data_ic2       <= block_at(pend_addr);
            pend                   <= 1'b0;
         end else begin
            pend_cnt <= pend_cnt - 3'd1;
         end
      end
   end

   // ====================================================================
   // stimulus
   // ====================================================================
   // kind 1 plain, 2 branch, 3 except or ertn, 4 stall, 5 mix
   task automatic drive_cycle(input int kind);
      logic [31:0] r;
      logic [31:0] t;
      br_taken          <= 1'b0;
      exu_ifu_except    <= 1'b0;
      exu_ifu_ertn_e    <= 1'b0;
      exu_ifu_stall_req <= 1'b0;
      take_bits(10, t);
      br_target <= {20'h00002, t[9:0], 2'b00};
      take_bits(10, t);
      exu_ifu_eentry <= {20'h00008, t[9:0], 2'b00};
      take_bits(10, t);
      exu_ifu_era <= {20'h00004, t[9:0], 2'b00};
      case (kind)
         2: begin
            take_bits(4, r);
            if (r[3:0] == 4'd0) br_taken <= 1'b1;
         end
         3: begin
            take_bits(4, r);
            if (r[3:0] == 4'd0) begin
               take_bits(2, r);
               // both at once now and then
               exu_ifu_except <= r[0];
               exu_ifu_ertn_e <= r[1] | ~r[0];
            end
         end
         4: begin
            take_bits(1, r);
            exu_ifu_stall_req <= r[0];
         end
         5: begin
            take_bits(2, r);
            exu_ifu_stall_req <= (r[1:0] == 2'd0);
            take_bits(4, r);
            if (r[3:0] == 4'd0) begin
               take_bits(3, r);
               br_taken       <= r[0];
               exu_ifu_except <= r[1];
               exu_ifu_ertn_e <= r[2];
            end
         end
         default: ;
      endcase
   endtask

   task automatic run_test(input int kind, input int n, input string name);
      int d0;
      int e0;
      d0 = dec_count;
      e0 = err_count;
      while (dec_count - d0 < n) begin
         @(posedge clk);
         drive_cycle(kind);
      end
      @(posedge clk);
      drive_cycle(1);
      @(posedge clk);
      // counters of the last edge settled
      @(negedge clk);
      if (err_count != e0) tests_failed++;
      $display("%s: %0d decodes, %0d errors", name, dec_count - d0, err_count - e0);
   endtask

   // bounded run
   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("timeout after %0d cycles with decodes still missing", cycles);
         $display("TEST FAILED");
         $finish;
      end
   end

   initial begin
      rst_n                  = 1'b0;
      br_taken               = 1'b0;
      br_target              = '0;
      exu_ifu_except         = 1'b0;
      exu_ifu_eentry         = '0;
      exu_ifu_ertn_e         = 1'b0;
      exu_ifu_era            = '0;
      exu_ifu_stall_req      = 1'b0;
      icu_ifu_data_ic2       = '0;
      icu_ifu_data_valid_ic2 = 1'b0;
      repeat (3) @(posedge clk);
      rst_n <= 1'b1;
      run_test(1, N_SEQ, "sequential fetch");
      run_test(2, N_BR, "branch redirect");
      run_test(3, N_EXC, "exception and return");
      run_test(4, N_STALL, "stall");
      run_test(5, N_MIX, "mixed random");
      $display("tests 5, failed %0d, decodes %0d, errors %0d",
               tests_failed, dec_count, err_count);
      if (tests_failed == 0 && err_count == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verification/ifu_checker.sv
`default_nettype none
`include "ifu_defs.svh"

module ifu_checker (
   input  wire                 clk,
   input  wire                 rst_n,
   input  wire [`GRLEN-1:0]    pc_init,
   input  wire                 br_taken,
   input  wire [`GRLEN-1:0]    br_target,
   input  wire                 exu_ifu_except,
   input  wire [`GRLEN-1:0]    exu_ifu_eentry,
   input  wire                 exu_ifu_ertn_e,
   input  wire [`GRLEN-1:0]    exu_ifu_era,
   input  wire                 exu_ifu_stall_req,
   input  wire                 ifu_icu_req_ic1,
   input  wire                 icu_ifu_ack_ic1,
   input  wire                 ifu_icu_cancel,
   input  wire                 icu_ifu_data_valid_ic2,
   input  wire [`GRLEN-1:0]    fdp_dec_pc_d,
   input  wire [`GRLEN-1:0]    fdp_dec_inst_d,
   input  wire                 fdp_dec_inst_kill_vld_d,
   input  wire                 ifu_exu_valid_e,
   input  wire [`GRLEN-1:0]    ifu_exu_pc_e,
   input  wire [`GRLEN-1:0]    ifu_exu_pc_w,
   output int                  dec_count,
   output int                  err_count
);

   import ifu_pkg::*;

   fetch_state_e      mem_state;    // fetch tracked from the port side
   logic [`GRLEN-1:0] exp_pc;       // next expected decode pc
   logic              exp_vld_e;    // decode moved on to e
   logic [`GRLEN-1:0] exp_pc_e;     // pc of that decode
   logic [`GRLEN-1:0] pc_e_q1;
   logic [`GRLEN-1:0] pc_e_q2;
   logic              stall_q;

   // instruction memory contents, a mix of the whole address
   function automatic logic [`GRLEN-1:0] mem_word(input logic [`GRLEN-1:0] a);
      return (a * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
   endfunction

   // ====================================================================
   // reference for the next decode pc
   // ====================================================================
   function automatic logic [`GRLEN-1:0] next_dec_pc(
      input logic [`GRLEN-1:0] cur,
      input logic              dec_vld,
      input logic              exc,
      input logic [`GRLEN-1:0] eentry,
      input logic              ertn,
      input logic [`GRLEN-1:0] era,
      input logic              br,
      input logic [`GRLEN-1:0] tgt
   );
      logic [`GRLEN-1:0] r;
      r = cur;
      // sequential step after each decode
      if (dec_vld) r = cur + 32'd4;
      // exception over ertn over branch
      if (exc) r = eentry;
      else if (ertn) r = era;
      else if (br) r = tgt;
      return r;
   endfunction

   always @(posedge clk) begin : compare
      int errs;
      errs = 0;
      if (!rst_n) begin
         exp_pc    <= pc_init;
         exp_vld_e <= 1'b0;
         mem_state <= FETCH_IDLE;
         dec_count <= 0;
         err_count <= 0;
         stall_q   <= 1'b0;
      end else begin
         // decode stream
         if (fdp_dec_inst_kill_vld_d) begin
            if (fdp_dec_pc_d !== exp_pc) begin
               $display("[ERROR] fdp_dec_pc_d: got %h expected %h", fdp_dec_pc_d, exp_pc);
               errs++;
            end
            if (fdp_dec_inst_d !== mem_word(exp_pc)) begin
               $display("[ERROR] fdp_dec_inst_d: got %h expected %h",
                        fdp_dec_inst_d, mem_word(exp_pc));
               errs++;
            end
            if (exu_ifu_stall_req) begin
               $display("decode was marked valid while the stall request was high");
               errs++;
            end
         end
         // e carries the last decode, one clock later
         if (ifu_exu_valid_e !== exp_vld_e) begin
            $display("[ERROR] ifu_exu_valid_e: got %h expected %h", ifu_exu_valid_e, exp_vld_e);
            errs++;
         end
         if (exp_vld_e && ifu_exu_pc_e !== exp_pc_e) begin
            $display("[ERROR] ifu_exu_pc_e: got %h expected %h", ifu_exu_pc_e, exp_pc_e);
            errs++;
         end
         // e frozen over a stall cycle
         if (stall_q && ifu_exu_pc_e !== pc_e_q1) begin
            $display("[ERROR] ifu_exu_pc_e: got %h expected %h", ifu_exu_pc_e, pc_e_q1);
            errs++;
         end
         // w is e two cycles late
         if (!$isunknown(pc_e_q2) && ifu_exu_pc_w !== pc_e_q2) begin
            $display("[ERROR] ifu_exu_pc_w: got %h expected %h", ifu_exu_pc_w, pc_e_q2);
            errs++;
         end
         // ================================================================
         // memory protocol
         // ================================================================
         if (ifu_icu_req_ic1 && mem_state == FETCH_BUSY && !ifu_icu_cancel) begin
            $display("request raised in state %s without a cancel", mem_state.name());
            errs++;
         end
         if (ifu_icu_cancel && mem_state == FETCH_IDLE) begin
            $display("cancel given in state %s with no fetch to drop", mem_state.name());
            errs++;
         end
         if (icu_ifu_ack_ic1) begin
            mem_state <= FETCH_BUSY;
         end else if (icu_ifu_data_valid_ic2 || ifu_icu_cancel) begin
            mem_state <= FETCH_IDLE;
         end
         // stall freezes e
         if (!exu_ifu_stall_req) begin
            exp_vld_e <= fdp_dec_inst_kill_vld_d;
         end
         if (fdp_dec_inst_kill_vld_d) begin
            exp_pc_e <= exp_pc;
         end
         exp_pc <= next_dec_pc(exp_pc, fdp_dec_inst_kill_vld_d, exu_ifu_except,
                               exu_ifu_eentry, exu_ifu_ertn_e, exu_ifu_era,
                               br_taken, br_target);
         dec_count <= dec_count + (fdp_dec_inst_kill_vld_d ? 1 : 0);
         err_count <= err_count + errs;
         stall_q   <= exu_ifu_stall_req;
      end
      pc_e_q1 <= ifu_exu_pc_e;
      pc_e_q2 <= pc_e_q1;
   end

endmodule

`default_nettype wire

// File: src/ifu_top.sv
`default_nettype none
`include "ifu_defs.svh"

module ifu_top (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire [`IFU_RST_VEC_W-1:0]   pc_init,
   // instruction memory
   output logic                       ifu_icu_req_ic1,
   output logic [`GRLEN-1:0]          ifu_icu_addr_ic1,
   input  wire                        icu_ifu_ack_ic1,
   output logic                       ifu_icu_cancel,
   input  wire [`IFU_BLOCK_W-1:0]     icu_ifu_data_ic2,
   input  wire                        icu_ifu_data_valid_ic2,
   // redirects from execute
   input  wire                        br_taken,
   input  wire [`GRLEN-1:0]           br_target,
   input  wire                        exu_ifu_except,
   input  wire [`GRLEN-1:0]           exu_ifu_eentry,
   input  wire                        exu_ifu_ertn_e,
   input  wire [`GRLEN-1:0]           exu_ifu_era,
   input  wire                        exu_ifu_stall_req,
   // decode and execute side
   output logic [`GRLEN-1:0]          fdp_dec_pc_d,
   output logic [`GRLEN-1:0]          fdp_dec_inst_d,
   output logic                       fdp_dec_inst_kill_vld_d,
   output logic                       ifu_exu_valid_e,
   output logic [`GRLEN-1:0]          ifu_exu_pc_e,
   output logic [`GRLEN-1:0]          ifu_exu_pc_w
);

   import ifu_pkg::*;

   // ====================================================================
   // internal links
   // ====================================================================
   logic [`GRLEN-1:0] pc_bf;
   logic [`GRLEN-1:0] pc_f;
   pc_src_e           pc_src;
   logic [`GRLEN-1:0] inst_f;
   logic              inst_valid_f;
   logic              iq_not_empty;
   logic              fetch_ahead;
   logic              flush_iq;

   // memory side
   ifu_fetch_req u_fetch_req (
      .clk                    (clk),
      .rst_n                  (rst_n),
      .pc_bf                  (pc_bf),
      .pc_src                 (pc_src),
      .iq_not_empty           (iq_not_empty),
      .fetch_ahead            (fetch_ahead),
      .exu_ifu_stall_req      (exu_ifu_stall_req),
      .icu_ifu_ack_ic1        (icu_ifu_ack_ic1),
      .icu_ifu_data_valid_ic2 (icu_ifu_data_valid_ic2),
      .ifu_icu_req_ic1        (ifu_icu_req_ic1),
      .ifu_icu_addr_ic1       (ifu_icu_addr_ic1),
      .ifu_icu_cancel         (ifu_icu_cancel),
      .flush_iq               (flush_iq)
   );

   // one block queue
   ifu_iq u_iq (
      .clk                    (clk),
      .rst_n                  (rst_n),
      .pc_f                   (pc_f),
      .exu_ifu_stall_req      (exu_ifu_stall_req),
      .flush_iq               (flush_iq),
      .icu_ifu_data_ic2       (icu_ifu_data_ic2),
      .icu_ifu_data_valid_ic2 (icu_ifu_data_valid_ic2),
      .inst_f                 (inst_f),
      .inst_valid_f           (inst_valid_f),
      .iq_not_empty           (iq_not_empty),
      .fetch_ahead            (fetch_ahead)
   );

   // pc select and stage pipe
   ifu_fdp u_fdp (
      .clk                     (clk),
      .rst_n                   (rst_n),
      .pc_init                 (pc_init),
      .br_taken                (br_taken),
      .br_target               (br_target),
      .exu_ifu_except          (exu_ifu_except),
      .exu_ifu_eentry          (exu_ifu_eentry),
      .exu_ifu_ertn_e          (exu_ifu_ertn_e),
      .exu_ifu_era             (exu_ifu_era),
      .exu_ifu_stall_req       (exu_ifu_stall_req),
      .inst_f                  (inst_f),
      .inst_valid_f            (inst_valid_f),
      .iq_not_empty            (iq_not_empty),
      .pc_bf                   (pc_bf),
      .pc_src                  (pc_src),
      .pc_f                    (pc_f),
      .fdp_dec_pc_d            (fdp_dec_pc_d),
      .fdp_dec_inst_d          (fdp_dec_inst_d),
      .fdp_dec_inst_kill_vld_d (fdp_dec_inst_kill_vld_d),
      .ifu_exu_valid_e         (ifu_exu_valid_e),
      .ifu_exu_pc_e            (ifu_exu_pc_e),
      .ifu_exu_pc_w            (ifu_exu_pc_w)
   );

endmodule

`default_nettype wire

// File: src/ifu_fdp.sv
`default_nettype none
`include "ifu_defs.svh"

module ifu_fdp (
   input  wire                        clk,
   input  wire                        rst_n,
   input  wire [`IFU_RST_VEC_W-1:0]   pc_init,
   input  wire                        br_taken,
   input  wire [`GRLEN-1:0]           br_target,
   input  wire                        exu_ifu_except,
   input  wire [`GRLEN-1:0]           exu_ifu_eentry,
   input  wire                        exu_ifu_ertn_e,
   input  wire [`GRLEN-1:0]           exu_ifu_era,
   input  wire                        exu_ifu_stall_req,
   input  wire [`GRLEN-1:0]           inst_f,
   input  wire                        inst_valid_f,
   input  wire                        iq_not_empty,
   output logic [`GRLEN-1:0]          pc_bf,
   output ifu_pkg::pc_src_e           pc_src,
   output logic [`GRLEN-1:0]          pc_f,
   output logic [`GRLEN-1:0]          fdp_dec_pc_d,
   output logic [`GRLEN-1:0]          fdp_dec_inst_d,
   output logic                       fdp_dec_inst_kill_vld_d,
   output logic                       ifu_exu_valid_e,
   output logic [`GRLEN-1:0]          ifu_exu_pc_e,
   output logic [`GRLEN-1:0]          ifu_exu_pc_w
);

   import ifu_pkg::*;

   localparam logic [`GRLEN-1:0] INST_BYTES = `GRLEN'(4);

   logic              init_q;      // first cycle out of reset
   logic              redirect;
   logic [`GRLEN-1:0] pc_inc_f;
   logic              vld_f;       // f valid after redirect kill
   logic              cap_f;       // f to d capture
   logic              vld_d_q;
   logic              vld_d_nxt;
   logic              kill_d;
   logic [`GRLEN-1:0] pc_m_q;

   // ====================================================================
   // next pc
   // ====================================================================
   assign redirect = br_taken | exu_ifu_except | exu_ifu_ertn_e;
   assign pc_inc_f = pc_f + INST_BYTES;

   // exception, then ertn, then branch
   always_comb begin
      if (exu_ifu_except) begin
         pc_src = PC_EXCEPT;
      end else if (exu_ifu_ertn_e) begin
         pc_src = PC_ERTN;
      end else if (br_taken) begin
         pc_src = PC_BRANCH;
      end else if (init_q) begin
         pc_src = PC_INIT;
      end else if (!exu_ifu_stall_req && iq_not_empty) begin
         pc_src = PC_INC;
      end else begin
         pc_src = PC_HOLD;
      end
   end

   always_comb begin
      case (pc_src)
         PC_INIT:   pc_bf = pc_init;
         PC_INC:    pc_bf = pc_inc_f;
         PC_BRANCH: pc_bf = br_target;
         PC_EXCEPT: pc_bf = exu_ifu_eentry;
         PC_ERTN:   pc_bf = exu_ifu_era;
         default:   pc_bf = pc_f;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         init_q <= 1'b1;
      end else begin
         init_q <= 1'b0;
      end
   end

   // bf to f, hold comes back through the mux
   always_ff @(posedge clk) begin
      pc_f <= pc_bf;
   end

   // ====================================================================
   // valid and kill
   // ====================================================================
   assign vld_f  = inst_valid_f & ~redirect;
   assign cap_f  = vld_f & ~exu_ifu_stall_req;
   // stall only delays d, redirect removes it
   assign kill_d = redirect | exu_ifu_stall_req;
   assign fdp_dec_inst_kill_vld_d = vld_d_q & ~kill_d;

   // frozen d entry still dies on a redirect
   assign vld_d_nxt = exu_ifu_stall_req ? (vld_d_q & ~redirect) : vld_f;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         vld_d_q         <= 1'b0;
         ifu_exu_valid_e <= 1'b0;
      end else begin
         vld_d_q <= vld_d_nxt;
         if (!exu_ifu_stall_req) begin
            ifu_exu_valid_e <= fdp_dec_inst_kill_vld_d;
         end
      end
   end

   // ====================================================================
   // stage registers
   // ====================================================================
   always_ff @(posedge clk) begin
      if (cap_f) begin
         fdp_dec_pc_d   <= pc_f;
         fdp_dec_inst_d <= inst_f;
      end
      // d to e, already gated by stall
      if (fdp_dec_inst_kill_vld_d) begin
         ifu_exu_pc_e <= fdp_dec_pc_d;
      end
      // m and w advance every cycle
      pc_m_q       <= ifu_exu_pc_e;
      ifu_exu_pc_w <= pc_m_q;
   end

endmodule

`default_nettype wire

// File: src/ifu_iq.sv
`default_nettype none
`include "ifu_defs.svh"

module ifu_iq (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire [`GRLEN-1:0]         pc_f,
   input  wire                      exu_ifu_stall_req,
   input  wire                      flush_iq,
   input  wire [`IFU_BLOCK_W-1:0]   icu_ifu_data_ic2,
   input  wire                      icu_ifu_data_valid_ic2,
   output logic [`GRLEN-1:0]        inst_f,
   output logic                     inst_valid_f,
   output logic                     iq_not_empty,
   output logic                     fetch_ahead
);

   // held block and its flag
   logic [`IFU_BLOCK_W-1:0] blk_q;
   logic                    blk_vld_q;
   logic                    blk_vld_d;

   // block seen at f this cycle
   logic [`IFU_BLOCK_W-1:0] blk_cur;
   logic                    hi_word;
   logic                    consume;
   logic                    drain;

   // ====================================================================
   // word select
   // ====================================================================

   // bypass the returning block in its arrival cycle
   assign blk_cur = icu_ifu_data_valid_ic2 ? icu_ifu_data_ic2 : blk_q;

   // pc bit 2 picks the half, low word at the lower address
   assign hi_word = pc_f[2];
   assign inst_f  = hi_word ? blk_cur[`IFU_BLOCK_W-1:`GRLEN] : blk_cur[`GRLEN-1:0];

   // something to hand out, held or arriving
   assign iq_not_empty = blk_vld_q | icu_ifu_data_valid_ic2;
   // a flushed block delivers nothing
   assign inst_valid_f = iq_not_empty & ~flush_iq;

   // word leaves f only when not stalled
   assign consume = inst_valid_f & ~exu_ifu_stall_req;
   // high word taken, block used up
   assign drain   = consume & hi_word;

   // low word in use, next block may be asked for early
   // stall gating done on the request side
   assign fetch_ahead = inst_valid_f & ~hi_word;

   // ====================================================================
   // block storage
   // ====================================================================
   always_comb begin
      if (flush_iq || drain) begin
         blk_vld_d = 1'b0;
      end else if (icu_ifu_data_valid_ic2) begin
         blk_vld_d = 1'b1;
      end else begin
         blk_vld_d = blk_vld_q;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         blk_vld_q <= 1'b0;
      end else begin
         blk_vld_q <= blk_vld_d;
      end
   end

   // payload, qualified by blk_vld_q
   always_ff @(posedge clk) begin
      if (icu_ifu_data_valid_ic2) begin
         blk_q <= icu_ifu_data_ic2;
      end
   end

endmodule

`default_nettype wire

// File: src/ifu_fetch_req.sv
`default_nettype none
`include "ifu_defs.svh"

module ifu_fetch_req (
   input  wire                 clk,
   input  wire                 rst_n,
   input  wire [`GRLEN-1:0]    pc_bf,
   input  ifu_pkg::pc_src_e    pc_src,
   input  wire                 iq_not_empty,
   input  wire                 fetch_ahead,
   input  wire                 exu_ifu_stall_req,
   input  wire                 icu_ifu_ack_ic1,
   input  wire                 icu_ifu_data_valid_ic2,
   output logic                ifu_icu_req_ic1,
   output logic [`GRLEN-1:0]   ifu_icu_addr_ic1,
   output logic                ifu_icu_cancel,
   output logic                flush_iq
);

   import ifu_pkg::*;

   fetch_state_e state_q;
   fetch_state_e state_d;
   logic         busy;
   logic         redirect;
   logic         fetch_fin;

   // redirect seen through the pc mux opcode
   assign redirect = (pc_src == PC_BRANCH) || (pc_src == PC_EXCEPT) || (pc_src == PC_ERTN);
   assign busy     = (state_q == FETCH_BUSY);

   // ====================================================================
   // fetch in progress
   // ====================================================================

   // data of a cancelled fetch never comes back, so cancel ends it too
   assign fetch_fin = icu_ifu_data_valid_ic2 | ifu_icu_cancel;

   always_comb begin
      state_d = state_q;
      case (state_q)
         FETCH_IDLE: begin
            if (icu_ifu_ack_ic1) begin
               state_d = FETCH_BUSY;
            end
         end
         FETCH_BUSY: begin
            // refetch after cancel is acked at once, stay busy
            if (icu_ifu_ack_ic1) begin
               state_d = FETCH_BUSY;
            end else if (fetch_fin) begin
               state_d = FETCH_IDLE;
            end
         end
         default: state_d = FETCH_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= FETCH_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // ====================================================================
   // request, cancel, flush
   // ====================================================================

   // busy fetch is for the old path, drop it
   assign ifu_icu_cancel = redirect & busy;
   // old block in the queue is stale on any redirect
   assign flush_iq       = redirect;

   // empty queue or cancel refetch
   assign ifu_icu_req_ic1 = ifu_icu_cancel | (~busy & ~iq_not_empty);
   assign ifu_icu_addr_ic1 = pc_bf;

endmodule

`default_nettype wire

// File: src/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

   // ====================================================================
   // fetch tracking on the memory side
   // ====================================================================

   // one outstanding fetch at most
   typedef enum logic {
      FETCH_IDLE = 1'b0,
      FETCH_BUSY = 1'b1   // acked, data or cancel still to come
   } fetch_state_e;

   // ====================================================================
   // next pc source, the opcode of the pc_bf mux
   // ====================================================================
   typedef enum logic [2:0] {
      PC_INIT   = 3'd0,   // reset vector
      PC_HOLD   = 3'd1,   // stall or empty queue
      PC_INC    = 3'd2,   // queue delivers, pc_f + 4
      PC_BRANCH = 3'd3,   // taken branch from e
      PC_EXCEPT = 3'd4,   // exception entry
      PC_ERTN   = 3'd5    // return from exception
   } pc_src_e;

endpackage

`default_nettype wire

// File: include/ifu_defs.svh
`ifndef IFU_DEFS_SVH
`define IFU_DEFS_SVH

// general register width, also the pc width
`define GRLEN 32

// one return from the instruction memory
// holds two instructions, low word first
`define IFU_BLOCK_W 64

// reset vector width, muxed straight into pc_bf
`define IFU_RST_VEC_W `GRLEN

`endif
